// ==== flist.f ====
+incdir+logic
logic/flit_pkg.sv
logic/link_pkg.sv
logic/flit_source.sv
logic/rep_buffer_4.sv
logic/flit_sink.sv
logic/flit_link_top.sv
tests/tb_flit_link.sv

// ==== Bender.yml ====
package:
  name: flit_link

sources:
  - include_dirs:
      - logic
    files:
      - logic/flit_pkg.sv
      - logic/link_pkg.sv
      - logic/flit_source.sv
      - logic/rep_buffer_4.sv
      - logic/flit_sink.sv
      - logic/flit_link_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_flit_link.sv

// ==== tests/link_cases.txt ====
# name         dest len seed     stall checksum
# stall is the percent of cycles with sink_ready low, 100 holds it low for 20 cycles
single_flit    05   1   12345678 0     048d159e00000000
long_hold      7e   31  deadbeef 100   37ab6fbbc000001f
pair           01   2   a5a5a5a5 0     0000000000000001
rand_a         10   7   00000001 50    0000000040000007
rand_b         22   13  cafef00d 50    32bfbc034000000c
rand_c         33   17  0badf00d 50    02eb7c0340000010
rand_d         44   5   ffffffff 50    3fffffffc0000004
rand_e         80   11  13579bdf 50    04d5e6f7c000000b
b2b_a          a0   3   00c0ffee 0     00303ffb80000003
b2b_b          a1   4   55aa55aa 0     0000000000000000
b2b_c          a2   9   87654321 25    21d950c840000008
long_rand      ff   31  00000000 50    000000000000001f

// ==== tests/tb_flit_link.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module tb_flit_link;
   import flit_pkg::*;

   localparam int MAX_CASES   = 32;
   localparam int HOLD_CYCLES = 20;   // Sink off time for a stall of 100

   logic     clk, rst_n, cmd_valid, cmd_ready, sink_ready, pkt_done, frame_error;
   dest_t    cmd_dest, pkt_dest;
   len_t     cmd_len, pkt_len;
   seed_t    cmd_seed;
   payload_t pkt_checksum;

   // One entry per line of the cases file
   string    names  [MAX_CASES];
   dest_t    dests  [MAX_CASES];
   len_t     lens   [MAX_CASES];
   seed_t    seeds  [MAX_CASES];
   int       stalls [MAX_CASES];
   payload_t sums   [MAX_CASES];
   int       n_cases, issued, reported, limit;
   int       rand_seed = 30870;

   flit_link_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_dest(input string name, input dest_t exp, input dest_t act);
      if (act !== exp)
         report_failure($sformatf("error %s: dest expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_len(input string name, input len_t exp, input len_t act);
      if (act !== exp)
         report_failure($sformatf("error %s: len expected %0d, actual %0d", name, exp, act));
   endtask

   task automatic check_sum(input string name, input payload_t exp, input payload_t act);
      if (act !== exp)
         report_failure($sformatf("error %s: checksum expected %h, actual %h",
                                  name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         report_failure($sformatf("error %s: expected %b, actual %b", name, exp, act));
   endtask

   // XOR of all data payloads with each one seed above flit index
   function automatic payload_t rule_sum(input seed_t seed, input len_t len);
      payload_t acc;
      int       i;
      acc = '0;
      for (i = 0; i < int'(len); i++)
         acc ^= {seed, i[`IDX_W-1:0]};
      return acc;
   endfunction

   task automatic load_cases;
      int                fd;
      int                total;
      int                len;
      int                stall;
      logic [8*160-1:0]  text_line;
      string             nm;
      logic [31:0]       dest;
      logic [31:0]       seed;
      logic [63:0]       sum;
      fd = $fopen("tests/link_cases.txt", "r");
      if (fd == 0)
         report_failure("could not open tests/link_cases.txt");
      total = 0;
      while (n_cases < MAX_CASES && $fgets(text_line, fd) > 0) begin
         // Comment and blank lines never give six fields
         if ($sscanf(text_line, "%s %h %d %h %d %h", nm, dest, len, seed, stall, sum) == 6) begin
            names[n_cases]  = nm;
            dests[n_cases]  = dest_t'(dest);
            lens[n_cases]   = len_t'(len);
            seeds[n_cases]  = seed_t'(seed);
            stalls[n_cases] = stall;
            sums[n_cases]   = payload_t'(sum);
            check_sum({nm, " file"}, rule_sum(seeds[n_cases], lens[n_cases]), sums[n_cases]);
            total += len + 1;
            n_cases++;
         end
      end
      $fclose(fd);
      limit = 8 * total + 200;
   endtask

   // Held until the source is idle and taken at the next edge
   task automatic send_cmd(input int k);
      cmd_valid = 1'b1;
      cmd_dest  = dests[k];
      cmd_len   = lens[k];
      cmd_seed  = seeds[k];
      @(negedge clk);
      while (!cmd_ready)
         @(negedge clk);
      @(posedge clk);
      #2;
      issued++;
   endtask

   initial begin
      int k;
      rst_n      = 1'b0;
      cmd_valid  = 1'b0;
      cmd_dest   = '0;
      cmd_len    = '0;
      cmd_seed   = '0;
      sink_ready = 1'b0;
      n_cases    = 0;
      issued     = 0;
      reported   = 0;
      load_cases();
      repeat (10) @(posedge clk);
      #2 rst_n = 1'b1;
      @(negedge clk);
      check_flag("reset cmd_ready", 1'b1, cmd_ready);
      check_flag("reset pkt_done", 1'b0, pkt_done);
      check_flag("reset frame_error", 1'b0, frame_error);
      @(posedge clk);
      #2;
      for (k = 0; k < n_cases; k++)
         send_cmd(k);
      cmd_valid = 1'b0;
      wait (reported == n_cases);
      repeat (20) @(negedge clk);   // Room for a stray pkt_done
      $display("TB PASSED");
      $finish;
   end

   // Sink pacing after the rising edge and report checks at the falling edge
   initial begin
      int cycles;
      int hold_cnt;
      int front;
      int pick;
      cycles   = 0;
      hold_cnt = 0;
      front    = 0;
      wait (rst_n === 1'b1);
      forever begin
         @(posedge clk);
         #2;
         hold_cnt = (front == reported) ? hold_cnt + 1 : 0;
         front    = reported;
         pick     = $unsigned($random(rand_seed)) % 100;
         if (reported >= n_cases)
            sink_ready = 1'b1;
         else if (stalls[reported] >= 100)
            sink_ready = (hold_cnt >= HOLD_CYCLES);
         else
            sink_ready = (pick >= stalls[reported]);
         @(negedge clk);
         cycles++;
         if (cycles > limit)
            report_failure($sformatf("timeout after %0d cycles with %0d of %0d packets reported",
                                     cycles, reported, n_cases));
         check_flag("link frame_error", 1'b0, frame_error);
         if (pkt_done) begin
            if (reported >= issued)
               report_failure("pkt_done seen with no command outstanding");
            check_dest(names[reported], dests[reported], pkt_dest);
            check_len(names[reported], lens[reported], pkt_len);
            check_sum(names[reported], sums[reported], pkt_checksum);
            reported++;
         end
      end
   end

endmodule

// ==== logic/flit_link_top.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module flit_link_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   input  flit_pkg::dest_t    cmd_dest,
   input  flit_pkg::len_t     cmd_len,
   input  flit_pkg::seed_t    cmd_seed,
   input  logic               sink_ready,
   output logic               pkt_done,
   output flit_pkg::dest_t    pkt_dest,
   output flit_pkg::len_t     pkt_len,
   output flit_pkg::payload_t pkt_checksum,
   output logic               frame_error
);

   logic [`FLIT_W-1:0] src_flit;
   logic               src_valid;
   logic               src_grant;
   logic [`FLIT_W-1:0] buf_flit;
   logic               buf_valid;
   logic               buf_grant;

   flit_source u_src (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_dest  (cmd_dest),
      .cmd_len   (cmd_len),
      .cmd_seed  (cmd_seed),
      .src_flit  (src_flit),
      .src_valid (src_valid),
      .src_grant (src_grant)
   );

   rep_buffer_4 #(
      .DATAWIDTH (`FLIT_W)
   ) u_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .data_in   (src_flit),
      .valid_in  (src_valid),
      .grant_out (src_grant),
      .data_out  (buf_flit),
      .valid_out (buf_valid),
      .grant_in  (buf_grant)
   );

   flit_sink u_sink (
      .clk          (clk),
      .rst_n        (rst_n),
      .buf_flit     (buf_flit),
      .buf_valid    (buf_valid),
      .buf_grant    (buf_grant),
      .sink_ready   (sink_ready),
      .pkt_done     (pkt_done),
      .pkt_dest     (pkt_dest),
      .pkt_len      (pkt_len),
      .pkt_checksum (pkt_checksum),
      .frame_error  (frame_error)
   );

endmodule

// ==== logic/flit_sink.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module flit_sink (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`FLIT_W-1:0]  buf_flit,
   input  logic                buf_valid,
   output logic                buf_grant,
   input  logic                sink_ready,
   output logic                pkt_done,
   output flit_pkg::dest_t     pkt_dest,
   output flit_pkg::len_t      pkt_len,
   output flit_pkg::payload_t  pkt_checksum,
   output logic                frame_error
);
   import flit_pkg::*;
   import link_pkg::*;

   sink_state_e state;
   sink_state_e state_nxt;
   flit_type_e  ftype;
   payload_t    payload;
   len_t        cnt;        // Data flits so far
   logic        accept;
   logic        in_pkt;
   logic        is_data;

   assign buf_grant = sink_ready;
   assign accept    = buf_valid & sink_ready;
   assign ftype     = flit_type_e'(buf_flit[`FLIT_W-1 -: 2]);
   assign payload   = buf_flit[`FLIT_W-3:0];
   assign in_pkt    = (state == SNK_IN_PKT);
   assign is_data   = (ftype == FT_BODY) || (ftype == FT_TAIL);
   assign pkt_done  = (state == SNK_REPORT);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= SNK_WAIT_HEAD;
      else
         state <= state_nxt;
   end

   // REPORT also takes a new head so no flit is dropped
   always_comb begin
      state_nxt = state;
      case (state)
         SNK_WAIT_HEAD, SNK_REPORT:
            if (accept && ftype == FT_HEAD)
               state_nxt = SNK_IN_PKT;
            else
               state_nxt = SNK_WAIT_HEAD;
         SNK_IN_PKT:
            if (accept && ftype == FT_TAIL)
               state_nxt = SNK_REPORT;
         default:
            state_nxt = SNK_WAIT_HEAD;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt         <= '0;
         frame_error <= 1'b0;
      end else if (accept) begin
         if (ftype == FT_HEAD) begin
            cnt         <= '0;
            frame_error <= in_pkt;   // Head inside a packet
         end else if (is_data) begin
            cnt <= cnt + 1'b1;
            if (!in_pkt)
               frame_error <= 1'b1;  // Data before any head
            else if (ftype == FT_TAIL && cnt + 1'b1 != pkt_len)
               frame_error <= 1'b1;
         end
      end
   end

   // Header fields and running XOR
   always_ff @(posedge clk) begin
      if (accept && ftype == FT_HEAD) begin
         pkt_dest     <= buf_flit[`FLIT_W-3 -: `DEST_W];
         pkt_len      <= buf_flit[`FLIT_W-3-`DEST_W -: `LEN_W];
         pkt_checksum <= '0;
      end else if (accept && is_data && in_pkt) begin
         pkt_checksum <= pkt_checksum ^ payload;
      end
   end

endmodule

// ==== logic/rep_buffer_4.sv ====
`timescale 1ns/1ps

module rep_buffer_4 #(
   parameter int DATAWIDTH = 64
) (
   input  logic                 clk,
   input  logic                 rst_n,

   // Push side
   input  logic [DATAWIDTH-1:0] data_in,
   input  logic                 valid_in,
   output logic                 grant_out,

   // Pop side
   output logic [DATAWIDTH-1:0] data_out,
   output logic                 valid_out,
   input  logic                 grant_in
);
   import link_pkg::*;

   buf_state_e cs;
   buf_state_e ns;

   logic [DATAWIDTH-1:0] ff [3];    // ff[0] holds the newest flit
   logic [DATAWIDTH-1:0] mux_out;
   logic                 enable_0;   // Reload output register
   logic                 enable_all; // Shift input into the stages
   logic [3:0]           sel;        // One-hot source for the output

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         cs <= EMPTY;
      else
         cs <= ns;
   end

   // Occupancy tracking
   always_comb begin
      case (cs)
         EMPTY:
            if (!valid_in)
               ns = EMPTY;
            else
               ns = FULL_1;
         FULL_1:
            if (!valid_in && grant_in)
               ns = EMPTY;
            else if (valid_in == grant_in)
               ns = FULL_1;
            else
               ns = FULL_2;
         FULL_2:
            if (!valid_in && grant_in)
               ns = FULL_1;
            else if (valid_in == grant_in)
               ns = FULL_2;
            else
               ns = FULL_3;
         FULL_3:
            if (!valid_in && grant_in)
               ns = FULL_2;
            else if (valid_in == grant_in)
               ns = FULL_3;
            else
               ns = FULL_ALL;
         FULL_ALL:
            if (!grant_in)
               ns = FULL_ALL;
            else
               ns = FULL_3;
         default:
            ns = EMPTY;
      endcase
   end

   always_comb begin
      case (cs)
         EMPTY: begin
            enable_0   = valid_in;   // Straight into output register
            enable_all = 1'b0;
            sel        = 4'b0001;
            valid_out  = 1'b0;
            grant_out  = 1'b1;
         end
         FULL_1: begin
            enable_0   = valid_in & grant_in;
            enable_all = valid_in & ~grant_in;
            sel        = 4'b0001;
            valid_out  = 1'b1;
            grant_out  = 1'b1;
         end
         FULL_2: begin
            enable_0   = grant_in;
            enable_all = valid_in;
            sel        = 4'b0010;
            valid_out  = 1'b1;
            grant_out  = 1'b1;
         end
         FULL_3: begin
            enable_0   = grant_in;
            enable_all = valid_in;
            sel        = 4'b0100;
            valid_out  = 1'b1;
            grant_out  = 1'b1;
         end
         FULL_ALL: begin
            enable_0   = grant_in;
            enable_all = 1'b0;
            sel        = 4'b1000;
            valid_out  = 1'b1;
            grant_out  = 1'b0;       // Only place the push side stalls
         end
         default: begin
            enable_0   = 1'b0;
            enable_all = 1'b0;
            sel        = 4'b0001;
            valid_out  = 1'b0;
            grant_out  = 1'b1;
         end
      endcase
   end

   // Oldest stored flit feeds the output
   always_comb begin
      case (sel)
         4'b0001: mux_out = data_in;
         4'b0010: mux_out = ff[0];
         4'b0100: mux_out = ff[1];
         4'b1000: mux_out = ff[2];
         default: mux_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (enable_0)
         data_out <= mux_out;
      if (enable_all) begin
         ff[0] <= data_in;
         ff[1] <= ff[0];
         ff[2] <= ff[1];
      end
   end

endmodule

// ==== logic/flit_source.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module flit_source (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cmd_valid,
   output logic                cmd_ready,
   input  flit_pkg::dest_t     cmd_dest,
   input  flit_pkg::len_t      cmd_len,
   input  flit_pkg::seed_t     cmd_seed,
   output logic [`FLIT_W-1:0]  src_flit,
   output logic                src_valid,
   input  logic                src_grant
);
   import flit_pkg::*;
   import link_pkg::*;

   // Unused bits between len and seed in the head
   localparam int HEAD_PAD = `FLIT_W - 2 - `DEST_W - `LEN_W - `SEED_W;

   src_state_e state;
   src_state_e state_nxt;
   dest_t      dest_q;
   len_t       len_q;
   seed_t      seed_q;
   len_t       idx;         // Data flit number
   logic       last_data;
   logic       xfer;
   flit_type_e data_type;

   assign cmd_ready = (state == SRC_IDLE);
   assign xfer      = src_valid & src_grant;
   assign last_data = (idx == len_q - 1'b1);
   assign data_type = last_data ? FT_TAIL : FT_BODY;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= SRC_IDLE;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         SRC_IDLE:
            if (cmd_valid)
               state_nxt = SRC_HEAD;
         SRC_HEAD:
            if (xfer)
               state_nxt = SRC_DATA;
         SRC_DATA:
            if (xfer && last_data)
               state_nxt = SRC_IDLE;
         default:
            state_nxt = SRC_IDLE;
      endcase
   end

   // Command fields held for the whole packet
   always_ff @(posedge clk) begin
      if (cmd_valid && cmd_ready) begin
         dest_q <= cmd_dest;
         len_q  <= cmd_len;
         seed_q <= cmd_seed;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         idx <= '0;
      else if (state == SRC_HEAD)
         idx <= '0;
      else if (state == SRC_DATA && xfer)
         idx <= idx + 1'b1;
   end

   // Flit held stable until granted
   always_comb begin
      src_flit  = '0;
      src_valid = 1'b0;
      case (state)
         SRC_HEAD: begin
            src_valid = 1'b1;
            src_flit  = {FT_HEAD, dest_q, len_q, {HEAD_PAD{1'b0}}, seed_q};
         end
         SRC_DATA: begin
            src_valid = 1'b1;
            src_flit  = {data_type, seed_q, {(`IDX_W - `LEN_W){1'b0}}, idx};
         end
         default: ;
      endcase
   end

endmodule

// ==== logic/link_pkg.sv ====
package link_pkg;

   // Occupancy of the elastic buffer
   typedef enum logic [2:0] {
      EMPTY,
      FULL_1,
      FULL_2,
      FULL_3,
      FULL_ALL
   } buf_state_e;

   typedef enum logic [1:0] {
      SRC_IDLE,
      SRC_HEAD,
      SRC_DATA
   } src_state_e;

   typedef enum logic [1:0] {
      SNK_WAIT_HEAD,
      SNK_IN_PKT,
      SNK_REPORT
   } sink_state_e;

endpackage

// ==== logic/flit_pkg.sv ====
`include "noc_defs.svh"

package flit_pkg;

   // Opcode carried in flit bits 63:62
   typedef enum logic [1:0] {
      FT_IDLE = 2'b00,
      FT_HEAD = 2'b01,
      FT_BODY = 2'b10,
      FT_TAIL = 2'b11
   } flit_type_e;

   // Head flit fields
   typedef logic [`DEST_W-1:0] dest_t;
   typedef logic [`LEN_W-1:0]  len_t;
   typedef logic [`SEED_W-1:0] seed_t;

   // Data flit payload with seed above index
   typedef logic [`SEED_W+`IDX_W-1:0] payload_t;

endpackage

// ==== logic/noc_defs.svh ====
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Link flit width
`define FLIT_W 64

// Head flit fields
`define DEST_W 8
`define LEN_W 5    // Data flit count of 1 to 31
`define SEED_W 32

// Index part of a data payload
`define IDX_W 30

`endif
